// ==== src/pf_settings.svh ====
`ifndef PF_SETTINGS_SVH
`define PF_SETTINGS_SVH

// One memory line holds two 32-bit words.
`define PF_LINE_BITS 64
`define PF_ADDR_BITS 32

// Line buffer of 8 entries.
`define PF_LOG2_DEPTH 3

// Free entries left when almost-full rises.
`define PF_ALMFULL_MARGIN 2

`endif

// ==== src/pf_pkg.sv ====
`include "pf_settings.svh"
`default_nettype none

package pf_pkg;

    typedef logic [`PF_ADDR_BITS-1:0] line_addr_t;
    typedef logic [`PF_LINE_BITS-1:0] line_data_t;
    typedef logic [31:0] line_count_t;
    typedef logic [15:0] tag_t;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_READ,
        ST_DONE
    } xfer_state_t;

    typedef struct packed
    {
        logic valid;
        line_addr_t address;
        tag_t tag;  // Low bits of the request index.
    } rd_req_t;

    typedef struct packed
    {
        logic valid;
        tag_t tag;
        line_data_t data;
    } rd_rsp_t;

endpackage

`default_nettype wire

// ==== src/line_fifo.sv ====
`timescale 1ns/10ps
`include "pf_settings.svh"
`default_nettype none

module line_fifo
#(
    parameter int WIDTH = 64,
    parameter int LOG2_DEPTH = 3
)
(
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic we,
    input  wire logic [WIDTH-1:0] wdata,
    input  wire logic re,

    output logic [WIDTH-1:0] rdata,
    output logic rvalid,
    output logic empty,
    output logic almostfull,
    output logic [LOG2_DEPTH:0] count
);

    localparam int DEPTH = 1 << LOG2_DEPTH;
    localparam int CW = LOG2_DEPTH + 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [LOG2_DEPTH-1:0] wr_ptr;
    logic [LOG2_DEPTH-1:0] rd_ptr;
    logic full;
    logic do_write;
    logic do_read;

    assign empty = (count == '0);
    assign full = (count == CW'(DEPTH));
    assign almostfull = (count >= CW'(DEPTH - `PF_ALMFULL_MARGIN));

    // Writes to a full FIFO are dropped.
    assign do_write = we && !full;
    assign do_read = re && !empty;

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= wdata;
        end
        if (do_read)
        begin
            rdata <= mem[rd_ptr];  // Valid with rvalid next cycle.
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            rvalid <= 1'b0;
        end
        else
        begin
            rvalid <= do_read;
            if (do_write)
            begin
                wr_ptr <= wr_ptr + LOG2_DEPTH'(1);
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + LOG2_DEPTH'(1);
            end
            count <= count + CW'(do_write) - CW'(do_read);
        end
    end

endmodule

`default_nettype wire

// ==== src/line_prefetch.sv ====
`timescale 1ns/10ps
`include "pf_settings.svh"
`default_nettype none

module line_prefetch
(
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic op_start,
    output logic op_done,

    input  wire pf_pkg::line_addr_t base,
    input  wire pf_pkg::line_count_t offset,
    input  wire pf_pkg::line_count_t length,

    input  wire logic mem_almfull,
    output pf_pkg::rd_req_t mem_req,
    input  wire pf_pkg::rd_rsp_t mem_rsp,

    output logic get_almfull,
    input  wire pf_pkg::rd_req_t get_req,
    output pf_pkg::rd_rsp_t get_rsp
);

    localparam int BUF_DEPTH = 1 << `PF_LOG2_DEPTH;

    pf_pkg::xfer_state_t req_state;
    pf_pkg::xfer_state_t rcv_state;

    pf_pkg::line_addr_t start_addr;
    pf_pkg::line_count_t xfer_length;

    pf_pkg::line_count_t req_count;      // Memory reads issued.
    pf_pkg::line_count_t log_count;      // Consumer requests logged.
    pf_pkg::line_count_t rsp_count;      // Memory responses buffered.
    pf_pkg::line_count_t deliver_count;  // Lines sent to the consumer.

    pf_pkg::line_count_t in_flight_next;
    pf_pkg::line_count_t buf_free;
    logic signed [31:0] credit;
    logic issue;

    logic buf_we;
    logic pop;
    pf_pkg::line_data_t buf_rdata;
    logic buf_rvalid;
    logic buf_empty;
    logic [`PF_LOG2_DEPTH:0] buf_count;

    logic pend_we;
    pf_pkg::tag_t pend_rdata;
    logic pend_rvalid;
    logic pend_empty;
    logic pend_almfull;
    logic [`PF_LOG2_DEPTH:0] pend_count;

    line_fifo
    #(
        .WIDTH(`PF_LINE_BITS),
        .LOG2_DEPTH(`PF_LOG2_DEPTH)
    )
    buffer_fifo
    (
        .clk,
        .reset,
        .we(buf_we),
        .wdata(mem_rsp.data),
        .re(pop),
        .rdata(buf_rdata),
        .rvalid(buf_rvalid),
        .empty(buf_empty),
        .almostfull(),
        .count(buf_count)
    );

    line_fifo
    #(
        .WIDTH($bits(pf_pkg::tag_t)),
        .LOG2_DEPTH(`PF_LOG2_DEPTH)
    )
    pending_fifo
    (
        .clk,
        .reset,
        .we(pend_we),
        .wdata(log_count[15:0]),
        .re(pop),
        .rdata(pend_rdata),
        .rvalid(pend_rvalid),
        .empty(pend_empty),
        .almostfull(pend_almfull),
        .count(pend_count)
    );

    assign buf_we = mem_rsp.valid && (rcv_state == pf_pkg::ST_READ);
    assign pend_we = get_req.valid && (req_state == pf_pkg::ST_READ);
    assign pop = !pend_empty && !buf_empty;  // One line per waiting request.

    always_comb
    begin
        issue = (req_state == pf_pkg::ST_READ) && (req_count < xfer_length) &&
                !mem_almfull && (credit > 0);
        in_flight_next = req_count + pf_pkg::line_count_t'(issue) - rsp_count;
        buf_free = pf_pkg::line_count_t'(BUF_DEPTH) - pf_pkg::line_count_t'(buf_count);
    end

    // Counts this cycle's issue so back-to-back reads cannot overrun the buffer.
    always_ff @(posedge clk)
    begin
        credit <= $signed(buf_free - in_flight_next);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_state <= pf_pkg::ST_IDLE;
            req_count <= '0;
            log_count <= '0;
            xfer_length <= '0;
            mem_req.valid <= 1'b0;
            get_almfull <= 1'b0;
        end
        else
        begin
            mem_req.valid <= 1'b0;
            get_almfull <= mem_almfull || ((req_state == pf_pkg::ST_READ) && pend_almfull);
            case (req_state)
                pf_pkg::ST_IDLE:
                begin
                    if (op_start)
                    begin
                        start_addr <= base + pf_pkg::line_addr_t'(offset);
                        xfer_length <= length;
                        req_count <= '0;
                        log_count <= '0;
                        req_state <= pf_pkg::ST_READ;
                    end
                end

                pf_pkg::ST_READ:
                begin
                    if (issue)
                    begin
                        mem_req.valid <= 1'b1;
                        mem_req.address <= start_addr + pf_pkg::line_addr_t'(req_count);
                        mem_req.tag <= req_count[15:0];
                        req_count <= req_count + 1;
                    end
                    if (pend_we)
                    begin
                        log_count <= log_count + 1;
                    end
                    if (req_count == xfer_length && log_count == xfer_length)
                    begin
                        req_state <= pf_pkg::ST_DONE;
                    end
                end

                default:
                begin
                    req_state <= pf_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rcv_state <= pf_pkg::ST_IDLE;
            rsp_count <= '0;
            deliver_count <= '0;
            get_rsp.valid <= 1'b0;
            op_done <= 1'b0;
        end
        else
        begin
            get_rsp.valid <= 1'b0;
            op_done <= 1'b0;
            case (rcv_state)
                pf_pkg::ST_IDLE:
                begin
                    if (op_start)
                    begin
                        rsp_count <= '0;
                        deliver_count <= '0;
                        rcv_state <= pf_pkg::ST_READ;
                    end
                end

                pf_pkg::ST_READ:
                begin
                    if (buf_we)
                    begin
                        rsp_count <= rsp_count + 1;
                    end
                    if (buf_rvalid && pend_rvalid)
                    begin
                        get_rsp.valid <= 1'b1;
                        get_rsp.tag <= pend_rdata;
                        get_rsp.data <= buf_rdata;
                        deliver_count <= deliver_count + 1;
                    end
                    if (deliver_count == xfer_length && pend_count == '0)
                    begin
                        rcv_state <= pf_pkg::ST_DONE;
                    end
                end

                default:
                begin
                    op_done <= 1'b1;
                    rcv_state <= pf_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/line_reduce.sv ====
`timescale 1ns/10ps
`include "pf_settings.svh"
`default_nettype none

module line_reduce
(
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic op_start,
    input  wire pf_pkg::line_count_t length,

    input  wire logic get_almfull,
    output pf_pkg::rd_req_t get_req,
    input  wire pf_pkg::rd_rsp_t get_rsp,

    output logic [31:0] checksum
);

    localparam int WORDS = `PF_LINE_BITS / 32;

    pf_pkg::line_count_t req_length;
    pf_pkg::line_count_t req_count;
    logic [31:0] line_sum;

    // Wraps modulo 2^32.
    always_comb
    begin
        line_sum = '0;
        for (int w = 0; w < WORDS; w++)
        begin
            line_sum = line_sum + get_rsp.data[w*32 +: 32];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_length <= '0;
            req_count <= '0;
            get_req.valid <= 1'b0;
            checksum <= '0;
        end
        else
        begin
            get_req.valid <= 1'b0;
            if (op_start)
            begin
                req_length <= length;
                req_count <= '0;
                checksum <= '0;
            end
            else
            begin
                if (!get_almfull && req_count < req_length)
                begin
                    get_req.valid <= 1'b1;
                    get_req.address <= pf_pkg::line_addr_t'(req_count);  // Index, not address.
                    get_req.tag <= req_count[15:0];
                    req_count <= req_count + 1;
                end
                if (get_rsp.valid)
                begin
                    checksum <= checksum + line_sum;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/prefetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module prefetch_top
(
    input  wire logic clk,
    input  wire logic reset,

    input  wire logic op_start,
    input  wire pf_pkg::line_addr_t base,
    input  wire pf_pkg::line_count_t offset,
    input  wire pf_pkg::line_count_t length,
    output logic op_done,
    output logic [31:0] checksum,

    input  wire logic mem_almfull,
    output pf_pkg::rd_req_t mem_req,
    input  wire pf_pkg::rd_rsp_t mem_rsp
);

    pf_pkg::rd_req_t get_req;
    pf_pkg::rd_rsp_t get_rsp;
    logic get_almfull;

    line_prefetch line_prefetch0
    (
        .clk,
        .reset,
        .op_start,
        .op_done,
        .base,
        .offset,
        .length,
        .mem_almfull,
        .mem_req,
        .mem_rsp,
        .get_almfull,
        .get_req,
        .get_rsp
    );

    line_reduce line_reduce0
    (
        .clk,
        .reset,
        .op_start,
        .length,
        .get_almfull,
        .get_req,
        .get_rsp,
        .checksum
    );

endmodule

`default_nettype wire

// ==== verif/prefetch_properties.sv ====
`timescale 1ns/10ps
`include "pf_settings.svh"
`default_nettype none

module prefetch_properties
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic mem_almfull,
    input  wire logic mem_req_valid,
    input  wire logic buf_we,
    input  wire logic [`PF_LOG2_DEPTH:0] buf_count,
    input  wire logic get_rsp_valid,
    input  wire pf_pkg::xfer_state_t rcv_state,
    input  wire logic op_done
);

    localparam logic [`PF_LOG2_DEPTH:0] BUF_DEPTH = (`PF_LOG2_DEPTH+1)'(1 << `PF_LOG2_DEPTH);

    // The request register lags the level by one cycle.
    req_held_off: assert property (@(posedge clk) disable iff (reset)
        $past(mem_almfull) |-> !mem_req_valid)
        else $error("Memory request issued while memory was almost full.");

    buffer_no_overflow: assert property (@(posedge clk) disable iff (reset)
        buf_we |-> (buf_count < BUF_DEPTH))
        else $error("Line buffer written while full.");

    rsp_not_idle: assert property (@(posedge clk) disable iff (reset)
        get_rsp_valid |-> (rcv_state != pf_pkg::ST_IDLE))
        else $error("Consumer response sent while receive FSM was idle.");

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        op_done |=> !op_done)
        else $error("op_done held for more than one cycle.");

endmodule

`default_nettype wire

// ==== verif/prefetch_tb.sv ====
`timescale 1ns/10ps
`include "pf_settings.svh"
`default_nettype none

module prefetch_tb;

    localparam int CASE_TIMEOUT = 5000;
    localparam int IDLE_CYCLES = 20;
    localparam int BUF_DEPTH = 1 << `PF_LOG2_DEPTH;
    localparam int MEM_ALMFULL_LEVEL = 6;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic op_start = 1'b0;
    pf_pkg::line_addr_t base = '0;
    pf_pkg::line_count_t offset = '0;
    pf_pkg::line_count_t length = '0;
    logic mem_almfull = 1'b0;
    pf_pkg::rd_rsp_t mem_rsp = '0;
    pf_pkg::rd_req_t mem_req;
    logic op_done;
    logic [31:0] checksum;

    int errors = 0;
    int timeouts = 0;
    logic [8*24-1:0] case_name = "reset";
    pf_pkg::line_addr_t case_start = '0;  // First line address of the case.
    int max_latency = 1;
    int req_seen = 0;
    int max_outstanding = 0;
    int cycle_count = 0;
    logic [31:0] rng_state = 32'd25;

    pf_pkg::line_addr_t pend_addr[$];
    pf_pkg::tag_t pend_tag[$];
    int pend_ready[$];

    always #50 clk = ~clk;

    prefetch_top dut0
    (
        .clk,
        .reset,
        .op_start,
        .base,
        .offset,
        .length,
        .op_done,
        .checksum,
        .mem_almfull,
        .mem_req,
        .mem_rsp
    );

    bind line_prefetch prefetch_properties props0
    (
        .clk(clk),
        .reset(reset),
        .mem_almfull(mem_almfull),
        .mem_req_valid(mem_req.valid),
        .buf_we(buf_we),
        .buf_count(buf_count),
        .get_rsp_valid(get_rsp.valid),
        .rcv_state(rcv_state),
        .op_done(op_done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %0s %0s: expected %h, actual %h", case_name, what, expected, actual);
            errors++;
        end
    endtask

    // In-order memory with a random latency per request.
    always @(posedge clk)
    begin
        pf_pkg::rd_rsp_t rsp;
        pf_pkg::line_addr_t addr;
        int latency;
        rsp = '0;
        if (reset)
        begin
            pend_addr.delete();
            pend_tag.delete();
            pend_ready.delete();
        end
        else
        begin
            if (op_start)
            begin
                req_seen = 0;
                max_outstanding = 0;
            end
            if (pend_ready.size() > 0 && pend_ready[0] <= cycle_count)
            begin
                addr = pend_addr.pop_front();
                rsp.valid = 1'b1;
                rsp.tag = pend_tag.pop_front();
                rsp.data = {addr, ~addr};  // High word address, low word inverse.
                void'(pend_ready.pop_front());
            end
            if (mem_req.valid)
            begin
                check_value("mem_req address", case_start + pf_pkg::line_addr_t'(req_seen),
                            mem_req.address);
                check_value("mem_req tag", 32'(req_seen[15:0]), 32'(mem_req.tag));
                rng_state = xorshift32(rng_state);
                latency = 1 + int'(rng_state % $unsigned(max_latency));
                pend_addr.push_back(mem_req.address);
                pend_tag.push_back(mem_req.tag);
                pend_ready.push_back(cycle_count + latency);
                req_seen++;
            end
            if (pend_addr.size() > max_outstanding)
            begin
                max_outstanding = pend_addr.size();
            end
        end
        mem_rsp <= rsp;
        mem_almfull <= (pend_addr.size() >= MEM_ALMFULL_LEVEL);
        cycle_count++;
    end

    task automatic run_case(input pf_pkg::line_addr_t c_base, input pf_pkg::line_count_t c_offset,
                            input pf_pkg::line_count_t c_length, input int c_latency,
                            input logic [31:0] c_checksum);
        int waited;
        int i;
        logic [31:0] model_sum;
        pf_pkg::line_addr_t a;
        case_start = c_base + pf_pkg::line_addr_t'(c_offset);
        max_latency = (c_latency < 1) ? 1 : c_latency;
        model_sum = '0;
        for (i = 0; i < int'(c_length); i++)
        begin
            a = case_start + pf_pkg::line_addr_t'(i);
            model_sum = model_sum + a + ~a;
        end
        check_value("case file checksum", model_sum, c_checksum);
        @(posedge clk);
        base <= c_base;
        offset <= c_offset;
        length <= c_length;
        op_start <= 1'b1;
        @(posedge clk);
        op_start <= 1'b0;
        waited = 0;
        while (!op_done && waited < CASE_TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (!op_done)
        begin
            $display("Case %0s: op_done never arrived within %0d cycles", case_name, CASE_TIMEOUT);
            timeouts++;
        end
        else
        begin
            check_value("checksum", model_sum, checksum);
            check_value("memory request count", c_length, 32'(req_seen));
            if (max_outstanding > BUF_DEPTH)
            begin
                $display("Case %0s: %0d requests were outstanding, more than the buffer holds",
                         case_name, max_outstanding);
                errors++;
            end
        end
        @(posedge clk);
    endtask

    initial
    begin
        int fd;
        int fields;
        int cases_run;
        string line_text;
        logic [8*24-1:0] name;
        pf_pkg::line_addr_t c_base;
        pf_pkg::line_count_t c_offset;
        pf_pkg::line_count_t c_length;
        int c_latency;
        logic [31:0] c_checksum;
        cases_run = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        case_name = "idle";
        repeat (IDLE_CYCLES)
        begin
            @(posedge clk);
            check_value("op_done", 32'd0, 32'(op_done));
            check_value("mem_req valid", 32'd0, 32'(mem_req.valid));
            check_value("checksum", 32'd0, checksum);
        end
        fd = $fopen("verif/prefetch_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the case file verif/prefetch_cases.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && timeouts == 0)
            begin
                line_text = "";
                if ($fgets(line_text, fd) > 0)
                begin
                    fields = $sscanf(line_text, "%s %h %h %d %d %h", name, c_base, c_offset,
                                     c_length, c_latency, c_checksum);
                    if (fields == 6)  // Comment and blank lines fall through.
                    begin
                        case_name = name;
                        cases_run++;
                        run_case(c_base, c_offset, c_length, c_latency, c_checksum);
                    end
                end
            end
            $fclose(fd);
        end
        if (cases_run == 0)
        begin
            $display("No cases were read from the case file");
            errors++;
        end
        $display("Cases run %0d, errors %0d, timeouts %0d", cases_run, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/pf_pkg.sv
src/line_fifo.sv
src/line_prefetch.sv
src/line_reduce.sv
src/prefetch_top.sv
verif/prefetch_properties.sv
verif/prefetch_tb.sv

// ==== Makefile ====
TOP       ?= prefetch_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -q "Simulation failed" $(LOG); then echo "Run FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi
	@echo "Run PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/prefetch_cases.txt ====
# name  base  offset  length  max_latency  checksum
# hex for base, offset and checksum; decimal for length and latency
single        00001000 00000000 1  1  ffffffff
short         00002000 00000010 5  3  fffffffb
exact_depth   00003000 00000004 8  4  fffffff8
over_depth    00004000 00000007 12 6  fffffff4
long_latency  00005000 00000020 40 20 ffffffd8
empty         00006000 00000000 0  5  00000000
after_empty   00007000 00000003 3  2  fffffffd
wrap_around   fffffff0 00000008 20 9  ffffffec
burst         00000000 00000000 64 1  ffffffc0
